// ==== rtl/axiPkg.sv ====
`default_nettype none

package axiPkg;

	// transaction ID width shared by both address channels
	localparam int unsigned IdBits = 4;

	// byte address width on the bus
	localparam int unsigned AddrBits = 32;

	// one data beat is one full word
	localparam int unsigned DataBits = 32;

	// one strobe per byte lane
	localparam int unsigned StrbBits = DataBits / 8;

	// burst length field, a value of n means n+1 beats
	localparam int unsigned LenBits = 4;

	// word address into the SRAM, taken from byte address bits 15 to 2
	localparam int unsigned WordAddrBits = 14;

	localparam int unsigned MemWords = 1 << WordAddrBits;

	// the only response this slave ever returns
	localparam logic [1:0] RespOkay = 2'b00;

	// controller states
	typedef enum logic [1:0] {
		idle      = 2'd0,
		readData  = 2'd1,
		writeData = 2'd2,
		writeResp = 2'd3
	} ctrlState;

endpackage

`default_nettype wire

// ==== rtl/burstDecode.sv ====
`timescale 1ns/1ps
`default_nettype none

module burstDecode (
	input  logic                                clk,
	input  logic                                rst,
	input  axiPkg::ctrlState                    state,
	input  logic                                arFire,
	input  logic                                awFire,
	input  logic                                rFire,
	input  logic                                wFire,
	input  logic [axiPkg::IdBits-1:0]           arId,
	input  logic [axiPkg::AddrBits-1:0]         arAddr,
	input  logic [axiPkg::LenBits-1:0]          arLen,
	input  logic [axiPkg::IdBits-1:0]           awId,
	input  logic [axiPkg::AddrBits-1:0]         awAddr,
	input  logic [axiPkg::LenBits-1:0]          awLen,
	output logic [axiPkg::WordAddrBits-1:0]     wordAddr,
	output logic                                lastBeat,
	output logic [axiPkg::IdBits-1:0]           rdId,
	output logic [axiPkg::IdBits-1:0]           wrId
);

	logic [axiPkg::WordAddrBits-1:0] curAddr;
	logic [axiPkg::WordAddrBits-1:0] nextAddr;
	logic [axiPkg::WordAddrBits-1:0] arWord;
	logic [axiPkg::WordAddrBits-1:0] awWord;
	logic [axiPkg::LenBits-1:0]      beatCnt;
	logic [axiPkg::LenBits-1:0]      burstLen;

	assign arWord = arAddr[axiPkg::WordAddrBits+1:2]; // byte offset bits are dropped
	assign awWord = awAddr[axiPkg::WordAddrBits+1:2];
	assign nextAddr = curAddr + 1'b1; // wraps at the top of the memory

	assign lastBeat = (beatCnt == burstLen);

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			curAddr  <= '0;
			beatCnt  <= '0;
			burstLen <= '0;
		end else if (arFire) begin
			curAddr  <= arWord;
			beatCnt  <= '0;
			burstLen <= arLen;
		end else if (awFire) begin
			curAddr  <= awWord;
			beatCnt  <= '0;
			burstLen <= awLen;
		end else if (rFire || wFire) begin
			curAddr <= nextAddr;
			beatCnt <= beatCnt + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (arFire) begin
			rdId <= arId;
		end
		if (awFire) begin
			wrId <= awId;
		end
	end

	// on a read beat the next word is already fetched so beats can go back to back
	always_comb begin
		case (state)
			axiPkg::idle: begin
				wordAddr = arFire ? arWord : awWord;
			end
			axiPkg::readData: begin
				wordAddr = (rFire && !lastBeat) ? nextAddr : curAddr;
			end
			default: begin
				wordAddr = curAddr;
			end
		endcase
	end

endmodule

`default_nettype wire

// ==== rtl/channelExec.sv ====
`timescale 1ns/1ps
`default_nettype none

module channelExec (
	input  logic                            clk,
	input  logic                            rst,
	input  logic                            arValid,
	input  logic                            awValid,
	input  logic                            rReady,
	input  logic                            wValid,
	input  logic                            wLast,
	input  logic [axiPkg::StrbBits-1:0]     wStrb,
	input  logic                            bReady,
	input  logic                            lastBeat,
	output axiPkg::ctrlState                state,
	output logic                            arReady,
	output logic                            awReady,
	output logic                            rValid,
	output logic                            wReady,
	output logic                            bValid,
	output logic                            arFire,
	output logic                            awFire,
	output logic                            rFire,
	output logic                            wFire,
	output logic                            memCs,
	output logic                            memOe,
	output logic [axiPkg::StrbBits-1:0]     memWe
);

	axiPkg::ctrlState nextState;
	logic bFire;

	// a pending write address blocks the read address in the same cycle
	assign arReady = (state == axiPkg::idle) && !awValid;
	assign awReady = (state == axiPkg::idle);
	assign rValid  = (state == axiPkg::readData);
	assign wReady  = (state == axiPkg::writeData);
	assign bValid  = (state == axiPkg::writeResp);

	assign arFire = arValid && arReady;
	assign awFire = awValid && awReady;
	assign rFire  = rValid && rReady;
	assign wFire  = wValid && wReady;
	assign bFire  = bValid && bReady;

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			state <= axiPkg::idle;
		end else begin
			state <= nextState;
		end
	end

	always_comb begin
		nextState = state;
		case (state)
			axiPkg::idle: begin
				if (awFire) begin
					nextState = axiPkg::writeData;
				end else if (arFire) begin
					nextState = axiPkg::readData;
				end
			end
			axiPkg::readData: begin
				if (rFire && lastBeat) begin
					nextState = axiPkg::idle;
				end
			end
			axiPkg::writeData: begin
				if (wFire && wLast) begin
					nextState = axiPkg::writeResp;
				end
			end
			default: begin
				if (bFire) begin
					nextState = axiPkg::idle;
				end
			end
		endcase
	end

	always_comb begin
		memCs = 1'b0;
		memOe = 1'b0;
		memWe = '0;
		case (state)
			axiPkg::idle: begin
				memCs = arValid || awValid;
				memOe = arFire; // first read word is fetched on the address edge
			end
			axiPkg::readData: begin
				memCs = rFire;
				memOe = rFire && !lastBeat; // nothing left to fetch after the last beat
			end
			axiPkg::writeData: begin
				memCs = wFire;
				memWe = wFire ? wStrb : '0;
			end
			default: begin
				memCs = 1'b0;
			end
		endcase
	end

endmodule

`default_nettype wire

// ==== rtl/sramArray.sv ====
`timescale 1ns/1ps
`default_nettype none

module sramArray (
	input  logic                                clk,
	input  logic [axiPkg::WordAddrBits-1:0]     wordAddr,
	input  logic [axiPkg::DataBits-1:0]         wrWord,
	input  logic                                memCs,
	input  logic                                memOe,
	input  logic [axiPkg::StrbBits-1:0]         memWe,
	output logic [axiPkg::DataBits-1:0]         rdWord
);

	logic [axiPkg::DataBits-1:0] mem [axiPkg::MemWords];
	logic anyWrite;

	assign anyWrite = |memWe;

	// byte lanes are written independently
	always_ff @(posedge clk) begin
		if (memCs) begin
			for (int lane = 0; lane < axiPkg::StrbBits; lane++) begin
				if (memWe[lane]) begin
					mem[wordAddr][8*lane +: 8] <= wrWord[8*lane +: 8];
				end
			end
		end
	end

	// read port keeps its last word until the next strobed read
	always_ff @(posedge clk) begin
		if (memCs && memOe && !anyWrite) begin
			rdWord <= mem[wordAddr];
		end
	end

endmodule

`default_nettype wire

// ==== rtl/respResult.sv ====
`timescale 1ns/1ps
`default_nettype none

module respResult (
	input  logic                            clk,
	input  logic                            rst,
	input  logic                            rValid,
	input  logic                            rFire,
	input  logic [axiPkg::DataBits-1:0]     rdWord,
	input  logic [axiPkg::IdBits-1:0]       rdId,
	input  logic [axiPkg::IdBits-1:0]       wrId,
	input  logic                            lastBeat,
	output logic [axiPkg::DataBits-1:0]     rData,
	output logic [axiPkg::IdBits-1:0]       rId,
	output logic [1:0]                      rResp,
	output logic                            rLast,
	output logic [axiPkg::IdBits-1:0]       bId,
	output logic [1:0]                      bResp
);

	logic stalled;
	logic [axiPkg::DataBits-1:0] heldWord;

	// set while the current beat has been shown for a cycle without being taken
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			stalled <= 1'b0;
		end else begin
			stalled <= rValid && !rFire;
		end
	end

	always_ff @(posedge clk) begin
		if (rValid && !stalled) begin
			heldWord <= rdWord; // live word is copied on the first cycle of each beat
		end
	end

	assign rData = stalled ? heldWord : rdWord;
	assign rLast = rValid && lastBeat;
	assign rId   = rdId;
	assign rResp = axiPkg::RespOkay;

	assign bId   = wrId;
	assign bResp = axiPkg::RespOkay;

endmodule

`default_nettype wire

// ==== rtl/axiSramTop.sv ====
`timescale 1ns/1ps
`default_nettype none

module axiSramTop (
	input  logic                                clk,
	input  logic                                rst,

	input  logic [axiPkg::IdBits-1:0]           arId,
	input  logic [axiPkg::AddrBits-1:0]         arAddr,
	input  logic [axiPkg::LenBits-1:0]          arLen,
	input  logic                                arValid,
	output logic                                arReady,

	output logic [axiPkg::IdBits-1:0]           rId,
	output logic [axiPkg::DataBits-1:0]         rData,
	output logic [1:0]                          rResp,
	output logic                                rLast,
	output logic                                rValid,
	input  logic                                rReady,

	input  logic [axiPkg::IdBits-1:0]           awId,
	input  logic [axiPkg::AddrBits-1:0]         awAddr,
	input  logic [axiPkg::LenBits-1:0]          awLen,
	input  logic                                awValid,
	output logic                                awReady,

	input  logic [axiPkg::DataBits-1:0]         wData,
	input  logic [axiPkg::StrbBits-1:0]         wStrb,
	input  logic                                wLast,
	input  logic                                wValid,
	output logic                                wReady,

	output logic [axiPkg::IdBits-1:0]           bId,
	output logic [1:0]                          bResp,
	output logic                                bValid,
	input  logic                                bReady
);

	axiPkg::ctrlState state;
	logic arFire;
	logic awFire;
	logic rFire;
	logic wFire;
	logic lastBeat;
	logic memCs;
	logic memOe;
	logic [axiPkg::StrbBits-1:0]     memWe;
	logic [axiPkg::WordAddrBits-1:0] wordAddr;
	logic [axiPkg::DataBits-1:0]     rdWord;
	logic [axiPkg::IdBits-1:0]       rdId;
	logic [axiPkg::IdBits-1:0]       wrId;

	burstDecode i_burstDecode (
		.clk      (clk),
		.rst      (rst),
		.state    (state),
		.arFire   (arFire),
		.awFire   (awFire),
		.rFire    (rFire),
		.wFire    (wFire),
		.arId     (arId),
		.arAddr   (arAddr),
		.arLen    (arLen),
		.awId     (awId),
		.awAddr   (awAddr),
		.awLen    (awLen),
		.wordAddr (wordAddr),
		.lastBeat (lastBeat),
		.rdId     (rdId),
		.wrId     (wrId)
	);

	channelExec i_channelExec (
		.clk      (clk),
		.rst      (rst),
		.arValid  (arValid),
		.awValid  (awValid),
		.rReady   (rReady),
		.wValid   (wValid),
		.wLast    (wLast),
		.wStrb    (wStrb),
		.bReady   (bReady),
		.lastBeat (lastBeat),
		.state    (state),
		.arReady  (arReady),
		.awReady  (awReady),
		.rValid   (rValid),
		.wReady   (wReady),
		.bValid   (bValid),
		.arFire   (arFire),
		.awFire   (awFire),
		.rFire    (rFire),
		.wFire    (wFire),
		.memCs    (memCs),
		.memOe    (memOe),
		.memWe    (memWe)
	);

	sramArray i_sramArray (
		.clk      (clk),
		.wordAddr (wordAddr),
		.wrWord   (wData), // write data goes straight into the array
		.memCs    (memCs),
		.memOe    (memOe),
		.memWe    (memWe),
		.rdWord   (rdWord)
	);

	respResult i_respResult (
		.clk      (clk),
		.rst      (rst),
		.rValid   (rValid),
		.rFire    (rFire),
		.rdWord   (rdWord),
		.rdId     (rdId),
		.wrId     (wrId),
		.lastBeat (lastBeat),
		.rData    (rData),
		.rId      (rId),
		.rResp    (rResp),
		.rLast    (rLast),
		.bId      (bId),
		.bResp    (bResp)
	);

endmodule

`default_nettype wire

// ==== tb/axiSramTbTasks.svh ====
`ifndef AXI_SRAM_TB_TASKS_SVH
`define AXI_SRAM_TB_TASKS_SVH

	task automatic checkData(input logic [axiPkg::DataBits-1:0] got,
			input logic [axiPkg::DataBits-1:0] exp, input string what);
		if (got !== exp) begin
			errors++;
			$display("ERR %0t: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic checkId(input logic [axiPkg::IdBits-1:0] got,
			input logic [axiPkg::IdBits-1:0] exp, input string what);
		if (got !== exp) begin
			errors++;
			$display("ERR %0t: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic checkResp(input logic [1:0] got, input logic [1:0] exp, input string what);
		if (got !== exp) begin
			errors++;
			$display("ERR %0t: %s is %b, expected %b", $time, what, got, exp);
		end
	endtask

	task automatic checkFlag(input logic got, input logic exp, input string what);
		if (got !== exp) begin
			errors++;
			$display("ERR %0t: %s is %b, expected %b", $time, what, got, exp);
		end
	endtask

	// one more cycle without progress, the run ends once a channel is stuck
	task automatic countStall(inout int waited, input string channel);
		waited++;
		if (waited > WaitLimit) begin
			errors++;
			$display("timeout: the %s channel stalled for %0d cycles at %0t", channel,
				WaitLimit, $time);
			finishRun();
		end
	endtask

	task automatic writeBurst(input logic [axiPkg::IdBits-1:0] id,
			input logic [axiPkg::AddrBits-1:0] addr, input logic [axiPkg::LenBits-1:0] len,
			input bit fullStrb);
		logic [axiPkg::WordAddrBits-1:0] cur;
		logic [axiPkg::DataBits-1:0] word;
		logic [31:0] r;
		int beat;
		int lane;
		int waited;
		bit took;
		cur = addr[axiPkg::WordAddrBits+1:2];
		@(negedge clk);
		{awId, awAddr, awLen} = {id, addr, len};
		awValid = 1'b1;
		waited = 0;
		@(posedge clk);
		while (!awReady) begin
			countStall(waited, "write address");
			@(posedge clk);
		end
		@(negedge clk);
		awValid = 1'b0;
		beat = 0;
		waited = 0;
		while (beat <= len) begin
			if (!wValid && !gapNow()) begin
				r = nextRand();
				wData = nextRand();
				wStrb = fullStrb ? '1 : r[31:28];
				wLast = (beat == len);
				wValid = 1'b1;
			end
			@(posedge clk);
			took = wValid && wReady;
			if (took) begin
				word = shadow[cur];
				for (lane = 0; lane < axiPkg::StrbBits; lane++) begin
					if (wStrb[lane]) begin
						word[8*lane +: 8] = wData[8*lane +: 8];
					end
				end
				shadow[cur] = word;
				cur = cur + 1'b1; // wraps like the slave's word address
				beat++;
				waited = 0;
			end else begin
				countStall(waited, "write data");
			end
			@(negedge clk);
			if (took) begin
				wValid = 1'b0;
			end
		end
		took = 1'b0;
		waited = 0;
		while (!took) begin
			bReady = !gapNow();
			@(posedge clk);
			took = bValid && bReady;
			if (took) begin
				checkId(bId, id, "bId");
				checkResp(bResp, axiPkg::RespOkay, "bResp");
				lastBTime = $time;
			end else begin
				countStall(waited, "write response");
			end
			@(negedge clk);
		end
		bReady = 1'b0;
	endtask

	task automatic readBurst(input logic [axiPkg::IdBits-1:0] id,
			input logic [axiPkg::AddrBits-1:0] addr, input logic [axiPkg::LenBits-1:0] len);
		logic [axiPkg::WordAddrBits-1:0] cur;
		int beat;
		int waited;
		bit done;
		cur = addr[axiPkg::WordAddrBits+1:2];
		@(negedge clk);
		{arId, arAddr, arLen} = {id, addr, len};
		arValid = 1'b1;
		waited = 0;
		@(posedge clk);
		while (!arReady) begin
			countStall(waited, "read address");
			@(posedge clk);
		end
		lastArTime = $time;
		for (beat = 0; beat <= len; beat++) begin
			expAddrQ.push_back(cur);
			expIdQ.push_back(id);
			expLastQ.push_back(beat == len);
			cur = cur + 1'b1;
		end
		@(negedge clk);
		arValid = 1'b0;
		done = 1'b0;
		waited = 0;
		while (!done) begin
			rReady = !gapNow();
			@(posedge clk);
			if (rValid && rReady) begin
				done = rLast;
				waited = 0;
			end else begin
				countStall(waited, "read data");
			end
			@(negedge clk);
		end
		rReady = 1'b0;
		if (expAddrQ.size() != 0) begin
			errors++;
			$display("a read burst ended at %0t with %0d beats missing", $time, expAddrQ.size());
			expAddrQ.delete();
			expIdQ.delete();
			expLastQ.delete();
		end
	endtask

`endif

// ==== tb/axiSramTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module axiSramTb;

	localparam logic [31:0] Seed = 32'hb0056078;
	localparam int WaitLimit = 200; // longest stall any channel may show
	localparam int SingleTests = 8;
	localparam int BurstTests = 20;
	localparam int StrobeTests = 10;
	localparam logic [31:0] TopAddr = (axiPkg::MemWords - 3) * 4; // three words below the top

	logic clk;
	logic rst;
	logic [axiPkg::IdBits-1:0] arId;
	logic [axiPkg::IdBits-1:0] rId;
	logic [axiPkg::IdBits-1:0] awId;
	logic [axiPkg::IdBits-1:0] bId;
	logic [axiPkg::AddrBits-1:0] arAddr;
	logic [axiPkg::AddrBits-1:0] awAddr;
	logic [axiPkg::LenBits-1:0] arLen;
	logic [axiPkg::LenBits-1:0] awLen;
	logic [axiPkg::DataBits-1:0] rData;
	logic [axiPkg::DataBits-1:0] wData;
	logic [axiPkg::StrbBits-1:0] wStrb;
	logic [1:0] rResp;
	logic [1:0] bResp;
	logic arValid;
	logic arReady;
	logic rValid;
	logic rReady;
	logic rLast;
	logic awValid;
	logic awReady;
	logic wValid;
	logic wReady;
	logic wLast;
	logic bValid;
	logic bReady;

	logic [31:0] rngState;
	logic [axiPkg::DataBits-1:0] shadow [axiPkg::MemWords];
	logic [axiPkg::WordAddrBits-1:0] expAddrQ [$];
	logic [axiPkg::IdBits-1:0] expIdQ [$];
	logic expLastQ [$];
	logic holdValid;
	logic [axiPkg::DataBits-1:0] holdData;
	bit useGaps;
	int errors;
	int errorsBefore;
	int testsDone;
	time lastBTime;
	time lastArTime;

	`include "axiSramTbTasks.svh"

	axiSramTop i_axiSramTop (.*);

	always #10 clk = ~clk;

	function automatic logic [31:0] nextRand();
		rngState = rngState * 32'd1664525 + 32'd1013904223;
		return rngState;
	endfunction

	// roughly one cycle in four is idle when gaps are on
	function automatic bit gapNow();
		logic [31:0] r;
		if (!useGaps) begin
			return 1'b0;
		end
		r = nextRand();
		return r[31:30] == 2'b00;
	endfunction

	function automatic logic [axiPkg::AddrBits-1:0] randAddr();
		logic [31:0] r;
		r = nextRand();
		return {r[15:0], r[31:18], 2'b00}; // bits above 15 are ignored by the slave
	endfunction

	// reference model returns the word the memory must hold at a word address
	function automatic logic [axiPkg::DataBits-1:0] expWord(
			input logic [axiPkg::WordAddrBits-1:0] addr);
		return shadow[addr];
	endfunction

	task automatic endTest(input string name);
		testsDone++;
		$display("test %0d (%s) finished with %0d errors", testsDone, name, errors - errorsBefore);
		errorsBefore = errors;
	endtask

	task automatic finishRun();
		$display("%0d tests run, %0d errors", testsDone, errors);
		if (errors == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	endtask

	// every read beat is checked on the edge where it is taken
	always @(posedge clk) begin
		if (rst) begin
			if (holdValid && rValid) begin
				checkData(rData, holdData, "rData under back-pressure");
			end
			if (rValid && rReady) begin
				if (expAddrQ.size() == 0) begin
					errors++;
					$display("a read beat arrived at %0t with no burst pending", $time);
				end else begin
					checkData(rData, expWord(expAddrQ.pop_front()), "rData");
					checkId(rId, expIdQ.pop_front(), "rId");
					checkFlag(rLast, expLastQ.pop_front(), "rLast");
					checkResp(rResp, axiPkg::RespOkay, "rResp");
				end
			end
			holdValid = rValid && !rReady;
			holdData = rData;
		end
	end

	initial begin
		logic [31:0] r;
		logic [axiPkg::AddrBits-1:0] addr;
		logic [axiPkg::LenBits-1:0] len;
		int i;
		clk = 1'b0;
		rst = 1'b0;
		{arId, arAddr, arLen, arValid} = '0;
		{awId, awAddr, awLen, awValid} = '0;
		{wData, wStrb, wLast, wValid} = '0;
		rReady = 1'b0;
		bReady = 1'b0;
		rngState = Seed;
		{holdValid, holdData} = '0;
		useGaps = 1'b0;
		errors = 0;
		errorsBefore = 0;
		testsDone = 0;
		lastBTime = 0;
		lastArTime = 0;
		repeat (16) @(negedge clk);
		rst = 1'b1;
		@(posedge clk);
		checkFlag(rValid, 1'b0, "rValid after reset");
		checkFlag(wReady, 1'b0, "wReady after reset");
		checkFlag(bValid, 1'b0, "bValid after reset");
		checkFlag(arReady, 1'b1, "arReady after reset");
		checkFlag(awReady, 1'b1, "awReady after reset");
		endTest("reset state");

		for (i = 0; i < SingleTests; i++) begin
			r = nextRand();
			addr = randAddr();
			writeBurst(r[31:28], addr, 4'd0, 1'b1);
			readBurst(r[27:24], addr, 4'd0);
		end
		endTest("single-beat write then read");

		for (i = 0; i < BurstTests; i++) begin
			r = nextRand();
			addr = (i == 0) ? TopAddr : randAddr(); // the first burst wraps to word zero
			len = (i == 0) ? 4'd7 : r[31:28];
			writeBurst(r[27:24], addr, len, 1'b1);
			readBurst(r[23:20], addr, len);
			if (i == 0) begin
				readBurst(r[19:16], '0, 4'd4); // the wrapped words are read again from word zero
			end
		end
		endTest("random bursts");

		for (i = 0; i < StrobeTests; i++) begin
			r = nextRand();
			addr = randAddr();
			writeBurst(r[27:24], addr, r[31:28], 1'b1);
			writeBurst(r[23:20], addr, r[31:28], 1'b0);
			readBurst(r[19:16], addr, r[31:28]);
		end
		endTest("byte strobes");

		useGaps = 1'b1;
		for (i = 0; i < BurstTests; i++) begin
			r = nextRand();
			addr = randAddr();
			writeBurst(r[27:24], addr, r[31:28], 1'b1);
			readBurst(r[23:20], addr, r[31:28]);
		end
		useGaps = 1'b0;
		r = nextRand();
		addr = randAddr();
		fork
			writeBurst(r[27:24], addr, r[31:28], 1'b1);
			readBurst(r[23:20], addr, r[31:28]);
		join
		checkFlag(lastBTime < lastArTime, 1'b1, "write done before read address");
		endTest("back-pressure and write priority");
		finishRun();
	end

endmodule

`default_nettype wire

// ==== axiSramTop.f ====
+incdir+tb
rtl/axiPkg.sv
rtl/burstDecode.sv
rtl/channelExec.sv
rtl/sramArray.sv
rtl/respResult.sv
rtl/axiSramTop.sv
tb/axiSramTb.sv

// ==== Bender.yml ====
package:
  name: axi_sram

sources:
  - rtl/axiPkg.sv
  - rtl/burstDecode.sv
  - rtl/channelExec.sv
  - rtl/sramArray.sv
  - rtl/respResult.sv
  - rtl/axiSramTop.sv
  - target: simulation
    include_dirs:
      - tb
    files:
      - tb/axiSramTb.sv
